// File: build.f
+incdir+src
src/dcache_addr_pkg.sv
src/dcache_ctrl_pkg.sv
src/dcache_way_if.sv
src/dcache_way_store.sv
src/dcache_ctrl.sv
src/dcache_top.sv
tests/tb_clock.sv
tests/dcache_mem_model.sv
tests/dcache_props.sv
tests/dcache_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the cache testbench with Verilator, runs it and looks for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb -f build.f \
    > build.log 2>&1 \
    && ./obj_dir/Vdcache_tb > sim.log 2>&1 \
    || echo "Build or simulation ended with an error, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -qs "^TB PASSED$" sim.log && echo "Simulation passed" && exit 0
echo "Simulation failed"
exit 1

// File: src/dcache_addr_pkg.sv
// Address and data word types for the data cache.
`default_nettype none

`include "dcache_params.svh"

package dcache_addr_pkg;

    typedef logic [`DCACHE_ADDR_W-1:0]  addr_t;
    typedef logic [`DCACHE_TAG_W-1:0]   tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0] index_t;
    typedef logic [`DCACHE_DATA_W-1:0]  word_t;
    typedef logic [`DCACHE_STRB_W-1:0]  strb_t;
    typedef logic                       way_t;
    typedef logic [`DCACHE_AGE_W-1:0]   age_t;

endpackage

`default_nettype wire

// File: src/dcache_ctrl.sv
// Request controller of the data cache.
// Serves one CPU request at a time and runs writeback and refill over a four-phase handshake.
`timescale 1ns/10ps
`default_nettype none

`include "dcache_params.svh"

module dcache_ctrl import dcache_addr_pkg::*, dcache_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst_i,
    dcache_way_if.ctrl way,
    input  logic       cpu_valid_i,
    input  logic       cpu_we_i,
    input  addr_t      cpu_addr_i,
    input  word_t      cpu_wdata_i,
    input  strb_t      cpu_strb_i,
    output logic       cpu_ready_o,
    output logic       cpu_resp_o,
    output word_t      cpu_rdata_o,
    output logic       mem_req_o,
    output mem_op_e    mem_op_o,
    output addr_t      mem_addr_o,
    output word_t      mem_wdata_o,
    input  logic       mem_ack_i,
    input  word_t      mem_rdata_i
);

    ctrl_state_e state_q;
    addr_t       req_addr_q;
    logic        req_we_q;
    word_t       req_wdata_q;
    strb_t       req_strb_q;
    word_t       rdata_q;
    word_t       fill_data_q;
    logic        fill_en_q;
    logic        mem_req_q;
    mem_op_e     mem_op_q;
    addr_t       mem_addr_q;
    word_t       mem_wdata_q;
    logic        accept;
    logic        lookup_hit;
    addr_t       line_addr;
    addr_t       victim_addr;

    assign accept      = cpu_valid_i && cpu_ready_o;
    assign lookup_hit  = (state_q == LOOKUP) && way.hit;
    assign line_addr   = {way.tag, way.index, {`DCACHE_OFFSET_W{1'b0}}};
    assign victim_addr = {way.victim_tag, way.index, {`DCACHE_OFFSET_W{1'b0}}};

    assign way.index     = req_addr_q[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign way.tag       = req_addr_q[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
    assign way.wdata     = req_wdata_q;
    assign way.hit_strb  = (lookup_hit && req_we_q) ? req_strb_q : '0;
    assign way.touch     = lookup_hit;
    assign way.fill_en   = fill_en_q;
    assign way.fill_data = fill_data_q;

    assign cpu_ready_o = (state_q == IDLE);
    assign cpu_resp_o  = (state_q == RESPOND);
    assign cpu_rdata_o = rdata_q;
    assign mem_req_o   = mem_req_q;
    assign mem_op_o    = mem_op_q;
    assign mem_addr_o  = mem_addr_q;
    assign mem_wdata_o = mem_wdata_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q   <= IDLE;
            mem_req_q <= 1'b0;
            fill_en_q <= 1'b0;
        end else begin
            fill_en_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        state_q <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (way.hit) begin
                        state_q <= RESPOND;
                    end else begin
                        mem_req_q <= 1'b1;
                        state_q   <= way.victim_dirty ? WB_REQ : FILL_REQ;
                    end
                end
                WB_REQ: begin
                    if (mem_ack_i) begin
                        mem_req_q <= 1'b0;
                        state_q   <= WB_RELEASE;
                    end
                end
                WB_RELEASE: begin
                    if (!mem_ack_i) begin
                        mem_req_q <= 1'b1;
                        state_q   <= FILL_REQ;
                    end
                end
                FILL_REQ: begin
                    if (mem_ack_i) begin
                        mem_req_q <= 1'b0;
                        fill_en_q <= 1'b1;
                        state_q   <= FILL_RELEASE;
                    end
                end
                // The fill lands while waiting here, so the next lookup hits.
                FILL_RELEASE: begin
                    if (!mem_ack_i) begin
                        state_q <= LOOKUP;
                    end
                end
                RESPOND: state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr_q  <= cpu_addr_i;
            req_we_q    <= cpu_we_i;
            req_wdata_q <= cpu_wdata_i;
            req_strb_q  <= cpu_strb_i;
        end
        if (lookup_hit) begin
            rdata_q <= way.hit_data;
        end
        if ((state_q == LOOKUP) && !way.hit) begin
            mem_op_q    <= way.victim_dirty ? MEM_OP_WRITEBACK : MEM_OP_REFILL;
            mem_addr_q  <= way.victim_dirty ? victim_addr : line_addr;
            mem_wdata_q <= way.victim_data;
        end
        if ((state_q == WB_RELEASE) && !mem_ack_i) begin
            mem_op_q   <= MEM_OP_REFILL;
            mem_addr_q <= line_addr;
        end
        if ((state_q == FILL_REQ) && mem_ack_i) begin
            fill_data_q <= mem_rdata_i;
        end
    end

endmodule

`default_nettype wire

// File: src/dcache_ctrl_pkg.sv
// Controller states and memory operations of the data cache.
`default_nettype none

package dcache_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE         = 3'd0,
        LOOKUP       = 3'd1,
        WB_REQ       = 3'd2,
        WB_RELEASE   = 3'd3,
        FILL_REQ     = 3'd4,
        FILL_RELEASE = 3'd5,
        RESPOND      = 3'd6
    } ctrl_state_e;

    typedef enum logic {
        MEM_OP_WRITEBACK = 1'b0,
        MEM_OP_REFILL    = 1'b1
    } mem_op_e;

endpackage

`default_nettype wire

// File: src/dcache_params.svh
// Data cache sizing for the two-way write-back cache.
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// CPU address and data word.
`define DCACHE_ADDR_W   32
`define DCACHE_DATA_W   64
`define DCACHE_STRB_W   8

// Address split into tag, set index and byte offset.
`define DCACHE_OFFSET_W 3
`define DCACHE_INDEX_W  6
`define DCACHE_TAG_W    23

`define DCACHE_SETS     64
`define DCACHE_AGE_W    3

`endif

// File: src/dcache_top.sv
// Two-way set-associative write-back data cache.
// Joins the request controller to the way store.
`timescale 1ns/10ps
`default_nettype none

module dcache_top import dcache_addr_pkg::*, dcache_ctrl_pkg::*; (
    input  logic    clk,
    input  logic    rst_i,
    input  logic    cpu_valid_i,
    input  logic    cpu_we_i,
    input  addr_t   cpu_addr_i,
    input  word_t   cpu_wdata_i,
    input  strb_t   cpu_strb_i,
    output logic    cpu_ready_o,
    output logic    cpu_resp_o,
    output word_t   cpu_rdata_o,
    output logic    mem_req_o,
    output mem_op_e mem_op_o,
    output addr_t   mem_addr_o,
    output word_t   mem_wdata_o,
    input  logic    mem_ack_i,
    input  word_t   mem_rdata_i
);

    dcache_way_if way_bus ();

    dcache_ctrl u_ctrl (
        .clk         (clk),
        .rst_i       (rst_i),
        .way         (way_bus),
        .cpu_valid_i (cpu_valid_i),
        .cpu_we_i    (cpu_we_i),
        .cpu_addr_i  (cpu_addr_i),
        .cpu_wdata_i (cpu_wdata_i),
        .cpu_strb_i  (cpu_strb_i),
        .cpu_ready_o (cpu_ready_o),
        .cpu_resp_o  (cpu_resp_o),
        .cpu_rdata_o (cpu_rdata_o),
        .mem_req_o   (mem_req_o),
        .mem_op_o    (mem_op_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_ack_i   (mem_ack_i),
        .mem_rdata_i (mem_rdata_i)
    );

    dcache_way_store u_store (
        .clk   (clk),
        .rst_i (rst_i),
        .way   (way_bus)
    );

endmodule

`default_nettype wire

// File: src/dcache_way_if.sv
// Lookup, update and victim signals between the cache controller and the way store.
`timescale 1ns/10ps
`default_nettype none

interface dcache_way_if import dcache_addr_pkg::*; ();

    index_t index;
    tag_t   tag;
    strb_t  hit_strb;
    word_t  wdata;
    logic   fill_en;
    word_t  fill_data;
    logic   touch;

    logic   hit;
    way_t   hit_way;
    word_t  hit_data;
    way_t   victim_way;
    logic   victim_dirty;
    tag_t   victim_tag;
    word_t  victim_data;

    modport ctrl (
        output index, tag, hit_strb, wdata, fill_en, fill_data, touch,
        input  hit, hit_way, hit_data, victim_way, victim_dirty, victim_tag, victim_data
    );

    modport store (
        input  index, tag, hit_strb, wdata, fill_en, fill_data, touch,
        output hit, hit_way, hit_data, victim_way, victim_dirty, victim_tag, victim_data
    );

endinterface

`default_nettype wire

// File: src/dcache_way_store.sv
// Two-way tag, data, dirty and age storage with hit detection and victim choice.
// Lookups are combinational, all updates land on the next clock edge.
`timescale 1ns/10ps
`default_nettype none

`include "dcache_params.svh"

module dcache_way_store import dcache_addr_pkg::*; (
    input  logic        clk,
    input  logic        rst_i,
    dcache_way_if.store way
);

    tag_t  tag_mem  [2][`DCACHE_SETS];
    word_t data_mem [2][`DCACHE_SETS];
    logic  valid_q  [2][`DCACHE_SETS];
    logic  dirty_q  [2][`DCACHE_SETS];
    age_t  age_q    [2][`DCACHE_SETS];

    logic [1:0] match;
    way_t       victim;
    way_t       other;
    word_t      merged;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            match[w] = valid_q[w][way.index] && (tag_mem[w][way.index] == way.tag);
        end
    end

    assign way.hit      = |match;
    assign way.hit_way  = match[1];
    assign way.hit_data = data_mem[way.hit_way][way.index];
    assign other        = ~way.hit_way;

    // An empty way is filled first, otherwise the older way goes.
    always_comb begin
        if (!valid_q[0][way.index]) begin
            victim = 1'b0;
        end else if (!valid_q[1][way.index]) begin
            victim = 1'b1;
        end else begin
            victim = (age_q[1][way.index] > age_q[0][way.index]);
        end
    end

    assign way.victim_way   = victim;
    assign way.victim_dirty = valid_q[victim][way.index] && dirty_q[victim][way.index];
    assign way.victim_tag   = tag_mem[victim][way.index];
    assign way.victim_data  = data_mem[victim][way.index];

    always_comb begin
        merged = way.hit_data;
        for (int b = 0; b < `DCACHE_STRB_W; b++) begin
            if (way.hit_strb[b]) begin
                merged[8*b +: 8] = way.wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (way.fill_en) begin
            tag_mem[victim][way.index]  <= way.tag;
            data_mem[victim][way.index] <= way.fill_data;
        end else if (way.touch) begin
            data_mem[way.hit_way][way.index] <= merged;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < `DCACHE_SETS; s++) begin
                    valid_q[w][s] <= 1'b0;
                    dirty_q[w][s] <= 1'b0;
                    age_q[w][s]   <= '0;
                end
            end
        end else if (way.fill_en) begin
            valid_q[victim][way.index] <= 1'b1;
            dirty_q[victim][way.index] <= 1'b0;
            age_q[victim][way.index]   <= '0;
        end else if (way.touch) begin
            age_q[way.hit_way][way.index] <= '0;
            // The other way ages and saturates at the top count.
            if (age_q[other][way.index] != '1) begin
                age_q[other][way.index] <= age_q[other][way.index] + 1'b1;
            end
            if (|way.hit_strb) begin
                dirty_q[way.hit_way][way.index] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/dcache_mem_model.sv
// Behavioural backing memory for the cache testbench.
// Answers the four-phase req/ack handshake after a delay set by the testbench.
`timescale 1ns/10ps
`default_nettype none

module dcache_mem_model import dcache_addr_pkg::*, dcache_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst_i,
    input  logic       mem_req_i,
    input  mem_op_e    mem_op_i,
    input  addr_t      mem_addr_i,
    input  word_t      mem_wdata_i,
    input  logic [2:0] ack_delay_i,
    output logic       mem_ack_o,
    output word_t      mem_rdata_o
);

    localparam word_t FILL_PATTERN = 64'hA5C3_0F96_5AE1_7B2D;

    word_t      store [addr_t];
    logic       ack_q   = 1'b0;
    word_t      rdata_q = '0;
    logic [2:0] wait_q;

    assign mem_ack_o   = ack_q;
    assign mem_rdata_o = rdata_q;

    always @(posedge clk) begin
        if (rst_i) begin
            ack_q  <= 1'b0;
            wait_q <= '0;
        end else if (mem_req_i && !ack_q) begin
            if (wait_q == ack_delay_i) begin
                ack_q  <= 1'b1;
                wait_q <= '0;
                if (mem_op_i == MEM_OP_WRITEBACK) begin
                    store[mem_addr_i] = mem_wdata_i;
                end else if (store.exists(mem_addr_i)) begin
                    rdata_q <= store[mem_addr_i];
                end else begin
                    // Lines never written read back as their address mixed with the pattern.
                    rdata_q <= word_t'(mem_addr_i) ^ FILL_PATTERN;
                end
            end else begin
                wait_q <= wait_q + 3'd1;
            end
        end else if (!mem_req_i && ack_q) begin
            ack_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: tests/dcache_props.sv
// Handshake properties of the data cache, bound to the top level.
`timescale 1ns/10ps
`default_nettype none

module dcache_props import dcache_addr_pkg::*, dcache_ctrl_pkg::*; (
    input logic    clk,
    input logic    rst_i,
    input logic    ready_i,
    input logic    resp_i,
    input logic    req_i,
    input mem_op_e op_i,
    input addr_t   addr_i,
    input word_t   wdata_i,
    input logic    ack_i
);

    // A pending memory request holds its op, address and data until ack.
    req_held: assert property (@(posedge clk) disable iff (rst_i)
        req_i && !ack_i |=> req_i && $stable(op_i) && $stable(addr_i) && $stable(wdata_i))
        else $error("memory request changed before ack");

    req_after_release: assert property (@(posedge clk) disable iff (rst_i)
        $rose(req_i) |-> !ack_i)
        else $error("memory request raised while ack still high");

    resp_pulse: assert property (@(posedge clk) disable iff (rst_i)
        resp_i |=> !resp_i)
        else $error("cpu response longer than one cycle");

    busy_during_mem: assert property (@(posedge clk) disable iff (rst_i)
        req_i |-> !ready_i)
        else $error("cpu ready high during a memory request");

endmodule

bind dcache_top dcache_props u_props (
    .clk     (clk),
    .rst_i   (rst_i),
    .ready_i (cpu_ready_o),
    .resp_i  (cpu_resp_o),
    .req_i   (mem_req_o),
    .op_i    (mem_op_o),
    .addr_i  (mem_addr_o),
    .wdata_i (mem_wdata_o),
    .ack_i   (mem_ack_i)
);

`default_nettype wire

// File: tests/dcache_tb.sv
// Testbench for the two-way write-back data cache.
// Tracks the expected cache state and checks read data, latency and memory traffic.
`timescale 1ns/10ps
`default_nettype none

`include "dcache_params.svh"

module dcache_tb import dcache_addr_pkg::*, dcache_ctrl_pkg::*; ();

    localparam int    NUM_REQ      = 14;
    localparam int    CYCLE_LIMIT  = 40 * NUM_REQ;
    localparam word_t FILL_PATTERN = 64'hA5C3_0F96_5AE1_7B2D;

    logic       clk;
    logic       rst_i;
    logic       cpu_valid_i;
    logic       cpu_we_i;
    addr_t      cpu_addr_i;
    word_t      cpu_wdata_i;
    strb_t      cpu_strb_i;
    logic       cpu_ready_o;
    logic       cpu_resp_o;
    word_t      cpu_rdata_o;
    logic       mem_req_o;
    mem_op_e    mem_op_o;
    addr_t      mem_addr_o;
    word_t      mem_wdata_o;
    logic       mem_ack_i;
    word_t      mem_rdata_i;
    logic [2:0] ack_delay;

    // Reference copy of both ways and of the backing memory.
    logic  m_valid [2][`DCACHE_SETS];
    logic  m_dirty [2][`DCACHE_SETS];
    tag_t  m_tag   [2][`DCACHE_SETS];
    word_t m_data  [2][`DCACHE_SETS];
    age_t  m_age   [2][`DCACHE_SETS];
    word_t backing [addr_t];

    logic  exp_wb;
    logic  exp_fill;
    addr_t exp_wb_addr;
    word_t exp_wb_data;
    addr_t exp_fill_addr;
    word_t exp_rdata;

    logic    accepted;
    logic    resp_seen;
    logic    req_prev;
    int      accept_cycle;
    int      resp_cycle;
    word_t   resp_data;
    mem_op_e seen_op   [$];
    addr_t   seen_addr [$];
    word_t   seen_data [$];

    logic [15:0] lfsr      = 16'd90;
    int          cycle     = 0;
    int          errors    = 0;
    int          err_base  = 0;
    int          tests_run = 0;

    tb_clock clock_gen (.clk_o(clk));

    dcache_mem_model mem (
        .clk         (clk),
        .rst_i       (rst_i),
        .mem_req_i   (mem_req_o),
        .mem_op_i    (mem_op_o),
        .mem_addr_i  (mem_addr_o),
        .mem_wdata_i (mem_wdata_o),
        .ack_delay_i (ack_delay),
        .mem_ack_o   (mem_ack_i),
        .mem_rdata_o (mem_rdata_i)
    );

    dcache_top UUT (
        .clk         (clk),
        .rst_i       (rst_i),
        .cpu_valid_i (cpu_valid_i),
        .cpu_we_i    (cpu_we_i),
        .cpu_addr_i  (cpu_addr_i),
        .cpu_wdata_i (cpu_wdata_i),
        .cpu_strb_i  (cpu_strb_i),
        .cpu_ready_o (cpu_ready_o),
        .cpu_resp_o  (cpu_resp_o),
        .cpu_rdata_o (cpu_rdata_o),
        .mem_req_o   (mem_req_o),
        .mem_op_o    (mem_op_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_ack_i   (mem_ack_i),
        .mem_rdata_i (mem_rdata_i)
    );

    // Fibonacci LFSR with taps 16, 14, 13 and 11, one step per bit.
    function automatic logic [63:0] lfsr_take(input int nbits);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[62:0], fb};
        end
        return v;
    endfunction

    function automatic strb_t random_strobes();
        strb_t s;
        s = strb_t'(lfsr_take(`DCACHE_STRB_W));
        return (s == '0) ? strb_t'(1) : s;
    endfunction

    function automatic addr_t make_addr(input tag_t tg, input index_t idx);
        return {tg, idx, {`DCACHE_OFFSET_W{1'b0}}};
    endfunction

    function automatic word_t mem_word(input addr_t line);
        if (backing.exists(line)) begin
            return backing[line];
        end
        return word_t'(line) ^ FILL_PATTERN;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Applies one request to the reference copy and records what the cache should do.
    task automatic predict(input logic we, input addr_t addr, input word_t wdata, input strb_t strb);
        index_t idx;
        tag_t   tg;
        int     hw;
        int     vw;
        idx = addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
        tg  = addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
        hw  = -1;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][idx] && m_tag[w][idx] == tg) begin
                hw = w;
            end
        end
        exp_wb        = 1'b0;
        exp_fill      = (hw < 0);
        exp_fill_addr = make_addr(tg, idx);
        if (hw < 0) begin
            if (!m_valid[0][idx]) begin
                vw = 0;
            end else if (!m_valid[1][idx]) begin
                vw = 1;
            end else begin
                vw = (m_age[1][idx] > m_age[0][idx]) ? 1 : 0;
            end
            if (m_valid[vw][idx] && m_dirty[vw][idx]) begin
                exp_wb               = 1'b1;
                exp_wb_addr          = make_addr(m_tag[vw][idx], idx);
                exp_wb_data          = m_data[vw][idx];
                backing[exp_wb_addr] = exp_wb_data;
            end
            m_valid[vw][idx] = 1'b1;
            m_dirty[vw][idx] = 1'b0;
            m_tag[vw][idx]   = tg;
            m_data[vw][idx]  = mem_word(exp_fill_addr);
            hw = vw;
        end
        exp_rdata = m_data[hw][idx];
        if (we) begin
            for (int b = 0; b < `DCACHE_STRB_W; b++) begin
                if (strb[b]) begin
                    m_data[hw][idx][8*b +: 8] = wdata[8*b +: 8];
                end
            end
            m_dirty[hw][idx] = 1'b1;
        end
        // The lookup after a refill hits too, so every request ages the other way.
        m_age[hw][idx] = '0;
        if (m_age[1-hw][idx] != '1) begin
            m_age[1-hw][idx] = age_t'(m_age[1-hw][idx] + 1);
        end
    endtask

    task automatic run_request(input logic we, input addr_t addr, input word_t wdata,
                               input strb_t strb);
        int n_exp;
        predict(we, addr, wdata, strb);
        n_exp = int'(exp_wb) + int'(exp_fill);
        seen_op.delete();
        seen_addr.delete();
        seen_data.delete();
        accepted  = 1'b0;
        resp_seen = 1'b0;
        @(posedge clk);
        cpu_valid_i <= 1'b1;
        cpu_we_i    <= we;
        cpu_addr_i  <= addr;
        cpu_wdata_i <= wdata;
        cpu_strb_i  <= strb;
        ack_delay   <= 3'(lfsr_take(3));
        do @(posedge clk); while (!accepted);
        cpu_valid_i <= 1'b0;
        do @(posedge clk); while (!resp_seen);
        assert (seen_op.size() == n_exp) else begin
            $display("Expected %0d memory requests for address %h but saw %0d",
                     n_exp, addr, seen_op.size());
            errors++;
        end
        if (seen_op.size() == n_exp && exp_wb) begin
            check_value("mem_op_o", seen_op[0], MEM_OP_WRITEBACK);
            check_value("mem_addr_o", seen_addr[0], exp_wb_addr);
            check_value("mem_wdata_o", seen_data[0], exp_wb_data);
        end
        if (seen_op.size() == n_exp && exp_fill) begin
            check_value("mem_op_o", seen_op[n_exp-1], MEM_OP_REFILL);
            check_value("mem_addr_o", seen_addr[n_exp-1], exp_fill_addr);
        end
        if (!exp_fill) begin
            assert (resp_cycle - accept_cycle == 2) else begin
                $display("Hit on %h answered %0d cycles after acceptance instead of 2",
                         addr, resp_cycle - accept_cycle);
                errors++;
            end
        end
        if (!we) begin
            check_value("cpu_rdata_o", resp_data, exp_rdata);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == err_base) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            $display("Test %0d %s: %0d checks failed", tests_run, name, errors - err_base);
        end
        err_base = errors;
    endtask

    // Outputs are sampled half a cycle after the edge, where they are settled.
    always @(negedge clk) begin
        if (!rst_i) begin
            if (cpu_valid_i && cpu_ready_o) begin
                accepted     = 1'b1;
                accept_cycle = cycle;
            end
            if (cpu_resp_o) begin
                resp_seen  = 1'b1;
                resp_cycle = cycle;
                resp_data  = cpu_rdata_o;
            end
            if (mem_req_o && !req_prev) begin
                seen_op.push_back(mem_op_o);
                seen_addr.push_back(mem_addr_o);
                seen_data.push_back(mem_wdata_o);
            end
            req_prev = mem_req_o;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with a request still open", cycle);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        word_t wdata;
        strb_t strb;
        addr_t a_addr;
        rst_i       = 1'b1;
        cpu_valid_i = 1'b0;
        cpu_we_i    = 1'b0;
        cpu_addr_i  = '0;
        cpu_wdata_i = '0;
        cpu_strb_i  = '0;
        ack_delay   = '0;
        accepted    = 1'b0;
        resp_seen   = 1'b0;
        req_prev    = 1'b0;
        for (int w = 0; w < 2; w++) begin
            for (int s = 0; s < `DCACHE_SETS; s++) begin
                m_valid[w][s] = 1'b0;
                m_dirty[w][s] = 1'b0;
                m_age[w][s]   = '0;
            end
        end
        repeat (5) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        check_value("cpu_ready_o", cpu_ready_o, 1'b1);
        check_value("cpu_resp_o", cpu_resp_o, 1'b0);
        check_value("mem_req_o", mem_req_o, 1'b0);
        end_test("reset state");

        a_addr = make_addr(23'd1, 6'd5);
        run_request(1'b0, a_addr, '0, '0);
        end_test("read miss on empty set");
        run_request(1'b0, a_addr, '0, '0);
        end_test("read hit");

        wdata = lfsr_take(`DCACHE_DATA_W);
        strb  = random_strobes();
        run_request(1'b1, a_addr, wdata, strb);
        run_request(1'b0, a_addr, '0, '0);
        end_test("write hit then read");

        // Set 9 ends with the dirty line as the older way, so the third tag evicts it.
        run_request(1'b0, make_addr(23'd2, 6'd9), '0, '0);
        wdata = lfsr_take(`DCACHE_DATA_W);
        strb  = random_strobes();
        run_request(1'b1, make_addr(23'd2, 6'd9), wdata, strb);
        run_request(1'b0, make_addr(23'd3, 6'd9), '0, '0);
        run_request(1'b0, make_addr(23'd4, 6'd9), '0, '0);
        run_request(1'b0, make_addr(23'd2, 6'd9), '0, '0);
        end_test("dirty eviction");

        run_request(1'b0, make_addr(23'd5, 6'd12), '0, '0);
        run_request(1'b0, make_addr(23'd6, 6'd12), '0, '0);
        run_request(1'b0, make_addr(23'd5, 6'd12), '0, '0);
        run_request(1'b0, make_addr(23'd7, 6'd12), '0, '0);
        run_request(1'b0, make_addr(23'd5, 6'd12), '0, '0);
        end_test("clean eviction");

        $display("%0d tests run, %0d checks failed", tests_run, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
// Free-running testbench clock with a 100 ns period.
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

endmodule

`default_nettype wire
